/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, result taken from sim.log
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module rs_alu_tb \
    -o rs_alu_sim > sim.log 2>&1 &&
./obj_dir/rs_alu_sim >> sim.log 2>&1 ||
echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

/* testbench/rs_alu_tests.svh */
task automatic set_slot_1(int a, addr_t pc, data_t op1, data_t op2, logic v1, logic v2,
                          data_t imm, rrf_tag_t tag, logic dst, alu_op_e aop);
    we_1_i            = 1'b1;
    write_addr_1_i    = ent_sel_t'(a);
    write_pc_1_i      = pc;
    write_op_1_1_i    = op1;
    write_op_1_2_i    = op2;
    write_valid_1_1_i = v1;
    write_valid_1_2_i = v2;
    write_imm_1_i     = imm;
    write_tag_1_i     = tag;
    write_dst_1_i     = dst;
    write_alu_op_1_i  = aop;
endtask

task automatic set_slot_2(int a, addr_t pc, data_t op1, data_t op2, logic v1, logic v2,
                          data_t imm, rrf_tag_t tag, logic dst, alu_op_e aop);
    we_2_i            = 1'b1;
    write_addr_2_i    = ent_sel_t'(a);
    write_pc_2_i      = pc;
    write_op_2_1_i    = op1;
    write_op_2_2_i    = op2;
    write_valid_2_1_i = v1;
    write_valid_2_2_i = v2;
    write_imm_2_i     = imm;
    write_tag_2_i     = tag;
    write_dst_2_i     = dst;
    write_alu_op_2_i  = aop;
endtask

task automatic broadcast(int b, rrf_tag_t tag, data_t val);
    fwd_valid_i[b]  = 1'b1;
    fwd_dst_i[b]    = tag;
    fwd_result_i[b] = val;
endtask

task automatic test_reset();
    check_vec("busy_vector_o", busy_vector_o, '0);
    check_vec("ready_o", ready_o, '0);
endtask

task automatic test_dual_write();
    set_slot_1(2, 32'h0000_1000, 32'h1111_0001, 32'h2222_0002, 1'b1, 1'b1,
               32'h0000_00aa, 6'h05, 1'b1, SUB);
    set_slot_2(5, 32'h0000_2004, 32'h3333_0003, 32'h4444_0004, 1'b1, 1'b1,
               32'hffff_fff0, 6'h2a, 1'b0, SLTU);
    advance();
    check_state();
    check_vec("busy_vector_o", busy_vector_o, 8'b0010_0100);
    check_entry(2);
    check_entry(5);
    clear_entry(2);
    clear_entry(5);
endtask

task automatic test_wakeup();
    set_slot_1(0, 32'h0000_3000, 32'h0000_0007, 32'h0000_0011, 1'b1, 1'b0,
               32'h0000_0010, 6'h08, 1'b1, XOR);
    advance();
    check_state();
    broadcast(0, 6'h12, 32'hdead_0012);
    advance();
    check_state();
    check_bit("ready_o[0]", ready_o[0], 1'b0);
    broadcast(1, 6'h11, 32'hcafe_0011);
    advance();
    check_state();
    check_bit("ready_o[0]", ready_o[0], 1'b1);
    check_entry(0);
    check_data("exe_op_2_o", exe_op_2_o, 32'hcafe_0011);
    clear_entry(0);
endtask

task automatic test_bypass();
    set_slot_2(3, 32'h0000_4000, 32'h0000_0021, 32'h0000_0009, 1'b0, 1'b1,
               32'h0000_0004, 6'h1c, 1'b0, SRA);
    broadcast(0, 6'h21, 32'hbeef_0021);
    advance();
    check_state();
    check_bit("ready_o[3]", ready_o[3], 1'b1);
    check_entry(3);
    clear_entry(3);
endtask

task automatic test_clear();
    set_slot_1(1, 32'h0000_5000, 32'h5, 32'h6, 1'b1, 1'b1, 32'h7, 6'h01, 1'b1, AND);
    set_slot_2(6, 32'h0000_6000, 32'h8, 32'h9, 1'b1, 1'b1, 32'ha, 6'h02, 1'b0, OR);
    advance();
    check_state();
    clear_entry(1);
    check_vec("busy_vector_o", busy_vector_o, 8'b0100_0000);
    check_entry(6);
    set_slot_1(1, 32'h0000_7000, 32'hb, 32'hc, 1'b1, 1'b1, 32'hd, 6'h03, 1'b0, SLL);
    advance();
    check_state();
    check_entry(1);
    clear_entry(1);
    clear_entry(6);
endtask

task automatic rand_slot(int slot, int a);
    logic [31:0] r [6];
    for (int i = 0; i < 6; i++) begin
        r[i] = $random(seed);
    end
    if (slot == 1) begin
        set_slot_1(a, r[0], r[1], r[2], r[5][0], r[5][1], r[3], r[4][5:0], r[5][2],
                   alu_op_e'(4'(r[4] % 10)));
    end else begin
        set_slot_2(a, r[0], r[1], r[2], r[5][0], r[5][1], r[3], r[4][5:0], r[5][2],
                   alu_op_e'(4'(r[4] % 10)));
    end
endtask

task automatic test_random_fill();
    logic [31:0] r;
    logic [31:0] v;
    rrf_tag_t    t0;
    rrf_tag_t    t1;
    for (int k = 0; k < ALU_ENT_NUM / 2; k++) begin
        rand_slot(1, 2 * k);
        rand_slot(2, 2 * k + 1);
        advance();
        check_state();
    end
    for (int c = 0; c < 6; c++) begin
        r  = $random(seed);
        v  = $random(seed);
        t0 = r[5:0];
        t1 = r[11:6];
        if (t1 == t0) begin
            t1 = t0 ^ 6'h01;
        end
        fwd_valid_i     = r[13:12];
        fwd_dst_i[0]    = t0;
        fwd_dst_i[1]    = t1;
        fwd_result_i[0] = v;
        fwd_result_i[1] = ~v;
        advance();
        check_state();
    end
    // wake whatever still waits
    for (int e = 0; e < ALU_ENT_NUM; e++) begin
        if (!(m_v1[e] && m_v2[e])) begin
            v = $random(seed);
            if (!m_v1[e]) begin
                broadcast(0, m_op1[e][RRF_SEL-1:0], v);
            end
            if (!m_v2[e] && !(fwd_valid_i[0] && fwd_dst_i[0] == m_op2[e][RRF_SEL-1:0])) begin
                broadcast(1, m_op2[e][RRF_SEL-1:0], ~v);
            end
            advance();
            check_state();
        end
    end
    for (int e = 0; e < ALU_ENT_NUM; e++) begin
        check_entry(e);
        clear_entry(e);
    end
endtask

/* testbench/rs_alu_tb.sv */
`timescale 1ns/1ps

module rs_alu_tb import rs_alu_pkg::*; ();

    logic                   clk_i;
    logic                   reset_i;
    logic                   we_1_i;
    ent_sel_t               write_addr_1_i;
    addr_t                  write_pc_1_i;
    data_t                  write_op_1_1_i;
    data_t                  write_op_1_2_i;
    logic                   write_valid_1_1_i;
    logic                   write_valid_1_2_i;
    data_t                  write_imm_1_i;
    rrf_tag_t               write_tag_1_i;
    logic                   write_dst_1_i;
    alu_op_e                write_alu_op_1_i;
    logic                   we_2_i;
    ent_sel_t               write_addr_2_i;
    addr_t                  write_pc_2_i;
    data_t                  write_op_2_1_i;
    data_t                  write_op_2_2_i;
    logic                   write_valid_2_1_i;
    logic                   write_valid_2_2_i;
    data_t                  write_imm_2_i;
    rrf_tag_t               write_tag_2_i;
    logic                   write_dst_2_i;
    alu_op_e                write_alu_op_2_i;
    logic [FWD_NUM-1:0]     fwd_valid_i;
    data_t                  fwd_result_i [FWD_NUM];
    rrf_tag_t               fwd_dst_i    [FWD_NUM];
    ent_sel_t               issue_addr_i;
    logic                   clear_busy_i;
    logic [ALU_ENT_NUM-1:0] busy_vector_o;
    logic [ALU_ENT_NUM-1:0] ready_o;
    addr_t                  exe_pc_o;
    data_t                  exe_op_1_o;
    data_t                  exe_op_2_o;
    data_t                  exe_imm_o;
    rrf_tag_t               exe_rrf_tag_o;
    logic                   exe_dst_val_o;
    alu_op_e                exe_alu_op_o;

    // reference model of the entries
    logic [ALU_ENT_NUM-1:0] m_busy;
    logic [ALU_ENT_NUM-1:0] m_v1;
    logic [ALU_ENT_NUM-1:0] m_v2;
    logic [ALU_ENT_NUM-1:0] m_dst;
    addr_t                  m_pc  [ALU_ENT_NUM];
    data_t                  m_op1 [ALU_ENT_NUM];
    data_t                  m_op2 [ALU_ENT_NUM];
    data_t                  m_imm [ALU_ENT_NUM];
    rrf_tag_t               m_tag [ALU_ENT_NUM];
    alu_op_e                m_aop [ALU_ENT_NUM];

    int errors;
    int checks;
    int seed;

    rs_alu i_rs_alu (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic check_vec(string name, logic [ALU_ENT_NUM-1:0] act,
                             logic [ALU_ENT_NUM-1:0] exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, act, exp);
        end
    endtask

    task automatic check_data(string name, data_t act, data_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, act, exp);
        end
    endtask

    task automatic check_addr(string name, addr_t act, addr_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, act, exp);
        end
    endtask

    task automatic check_tag(string name, rrf_tag_t act, rrf_tag_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, act, exp);
        end
    endtask

    task automatic check_op(string name, alu_op_e act, alu_op_e exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, act, exp);
        end
    endtask

    task automatic check_bit(string name, logic act, logic exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, act, exp);
        end
    endtask

    // any valid bus carrying the tag
    task automatic fwd_lookup(input rrf_tag_t tag, output logic hit, output data_t val);
        hit = 1'b0;
        val = '0;
        for (int b = 0; b < FWD_NUM; b++) begin
            if (fwd_valid_i[b] && fwd_dst_i[b] == tag) begin
                hit = 1'b1;
                val = fwd_result_i[b];
            end
        end
    endtask

    task automatic model_write(int e, addr_t pc, data_t op1, data_t op2, logic v1, logic v2,
                               data_t imm, rrf_tag_t tag, logic dst, alu_op_e aop);
        logic  hit;
        data_t val;
        m_busy[e] = 1'b1;
        m_pc[e]   = pc;
        m_imm[e]  = imm;
        m_tag[e]  = tag;
        m_dst[e]  = dst;
        m_aop[e]  = aop;
        m_op1[e]  = op1;
        m_op2[e]  = op2;
        m_v1[e]   = v1;
        m_v2[e]   = v2;
        // bypass from a bus in the write cycle
        if (!v1) begin
            fwd_lookup(op1[RRF_SEL-1:0], hit, val);
            if (hit) begin
                m_v1[e]  = 1'b1;
                m_op1[e] = val;
            end
        end
        if (!v2) begin
            fwd_lookup(op2[RRF_SEL-1:0], hit, val);
            if (hit) begin
                m_v2[e]  = 1'b1;
                m_op2[e] = val;
            end
        end
    endtask

    // next model state from the inputs seen at the coming edge
    task automatic model_edge();
        logic  hit;
        data_t val;
        for (int e = 0; e < ALU_ENT_NUM; e++) begin
            if (we_1_i && write_addr_1_i == ent_sel_t'(e)) begin
                model_write(e, write_pc_1_i, write_op_1_1_i, write_op_1_2_i,
                            write_valid_1_1_i, write_valid_1_2_i, write_imm_1_i,
                            write_tag_1_i, write_dst_1_i, write_alu_op_1_i);
            end else if (we_2_i && write_addr_2_i == ent_sel_t'(e)) begin
                model_write(e, write_pc_2_i, write_op_2_1_i, write_op_2_2_i,
                            write_valid_2_1_i, write_valid_2_2_i, write_imm_2_i,
                            write_tag_2_i, write_dst_2_i, write_alu_op_2_i);
            end else if (m_busy[e]) begin
                if (!m_v1[e]) begin
                    fwd_lookup(m_op1[e][RRF_SEL-1:0], hit, val);
                    if (hit) begin
                        m_v1[e]  = 1'b1;
                        m_op1[e] = val;
                    end
                end
                if (!m_v2[e]) begin
                    fwd_lookup(m_op2[e][RRF_SEL-1:0], hit, val);
                    if (hit) begin
                        m_v2[e]  = 1'b1;
                        m_op2[e] = val;
                    end
                end
                if (clear_busy_i && issue_addr_i == ent_sel_t'(e)) begin
                    m_busy[e] = 1'b0;
                end
            end
        end
    endtask

    task automatic idle_inputs();
        we_1_i       = 1'b0;
        we_2_i       = 1'b0;
        fwd_valid_i  = '0;
        clear_busy_i = 1'b0;
    endtask

    task automatic advance();
        model_edge();
        @(posedge clk_i);
        #10;
        idle_inputs();
    endtask

    task automatic check_state();
        check_vec("busy_vector_o", busy_vector_o, m_busy);
        check_vec("ready_o", ready_o, m_busy & m_v1 & m_v2);
    endtask

    task automatic check_entry(int e);
        issue_addr_i = ent_sel_t'(e);
        #1;
        check_addr("exe_pc_o", exe_pc_o, m_pc[e]);
        check_data("exe_op_1_o", exe_op_1_o, m_op1[e]);
        check_data("exe_op_2_o", exe_op_2_o, m_op2[e]);
        check_data("exe_imm_o", exe_imm_o, m_imm[e]);
        check_tag("exe_rrf_tag_o", exe_rrf_tag_o, m_tag[e]);
        check_bit("exe_dst_val_o", exe_dst_val_o, m_dst[e]);
        check_op("exe_alu_op_o", exe_alu_op_o, m_aop[e]);
    endtask

    task automatic clear_entry(int e);
        issue_addr_i = ent_sel_t'(e);
        clear_busy_i = 1'b1;
        advance();
        check_state();
    endtask

    `include "rs_alu_tests.svh"

    initial begin
        errors = 0;
        checks = 0;
        seed   = 91240;
        reset_i = 1'b1;
        issue_addr_i = '0;
        idle_inputs();
        set_slot_1(0, '0, '0, '0, 1'b0, 1'b0, '0, '0, 1'b0, ADD);
        set_slot_2(0, '0, '0, '0, 1'b0, 1'b0, '0, '0, 1'b0, ADD);
        we_1_i = 1'b0;
        we_2_i = 1'b0;
        for (int b = 0; b < FWD_NUM; b++) begin
            fwd_result_i[b] = '0;
            fwd_dst_i[b]    = '0;
        end
        m_busy = '0;
        m_v1   = '0;
        m_v2   = '0;
        m_dst  = '0;
        repeat (16) @(posedge clk_i);
        #10;
        reset_i = 1'b0;
        test_reset();
        test_dual_write();
        test_wakeup();
        test_bypass();
        test_clear();
        test_random_fill();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+testbench
verilog/rs_alu_pkg.sv
verilog/rs_dispatch_route.sv
verilog/rs_alu_entry.sv
verilog/rs_issue_select.sv
verilog/rs_alu.sv
testbench/rs_alu_tb.sv

/* verilog/rs_alu.sv */
`timescale 1ns/1ps

module rs_alu import rs_alu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_i,

    input  logic                   we_1_i,
    input  ent_sel_t               write_addr_1_i,
    input  addr_t                  write_pc_1_i,
    input  data_t                  write_op_1_1_i,
    input  data_t                  write_op_1_2_i,
    input  logic                   write_valid_1_1_i,
    input  logic                   write_valid_1_2_i,
    input  data_t                  write_imm_1_i,
    input  rrf_tag_t               write_tag_1_i,
    input  logic                   write_dst_1_i,
    input  alu_op_e                write_alu_op_1_i,

    input  logic                   we_2_i,
    input  ent_sel_t               write_addr_2_i,
    input  addr_t                  write_pc_2_i,
    input  data_t                  write_op_2_1_i,
    input  data_t                  write_op_2_2_i,
    input  logic                   write_valid_2_1_i,
    input  logic                   write_valid_2_2_i,
    input  data_t                  write_imm_2_i,
    input  rrf_tag_t               write_tag_2_i,
    input  logic                   write_dst_2_i,
    input  alu_op_e                write_alu_op_2_i,

    input  logic [FWD_NUM-1:0]     fwd_valid_i,
    input  data_t                  fwd_result_i [FWD_NUM],
    input  rrf_tag_t               fwd_dst_i    [FWD_NUM],

    input  ent_sel_t               issue_addr_i,
    input  logic                   clear_busy_i,

    output logic [ALU_ENT_NUM-1:0] busy_vector_o,
    output logic [ALU_ENT_NUM-1:0] ready_o,
    output addr_t                  exe_pc_o,
    output data_t                  exe_op_1_o,
    output data_t                  exe_op_2_o,
    output data_t                  exe_imm_o,
    output rrf_tag_t               exe_rrf_tag_o,
    output logic                   exe_dst_val_o,
    output alu_op_e                exe_alu_op_o
);

    // router to entries
    logic [ALU_ENT_NUM-1:0] route_we;
    addr_t                  route_pc     [ALU_ENT_NUM];
    data_t                  route_op_1   [ALU_ENT_NUM];
    data_t                  route_op_2   [ALU_ENT_NUM];
    logic [ALU_ENT_NUM-1:0] route_op_1_valid;
    logic [ALU_ENT_NUM-1:0] route_op_2_valid;
    data_t                  route_imm    [ALU_ENT_NUM];
    rrf_tag_t               route_tag    [ALU_ENT_NUM];
    logic [ALU_ENT_NUM-1:0] route_dst;
    alu_op_e                route_alu_op [ALU_ENT_NUM];

    // entries to selector
    logic [ALU_ENT_NUM-1:0] ent_clear;
    addr_t                  ent_pc       [ALU_ENT_NUM];
    data_t                  ent_op_1     [ALU_ENT_NUM];
    data_t                  ent_op_2     [ALU_ENT_NUM];
    data_t                  ent_imm      [ALU_ENT_NUM];
    rrf_tag_t               ent_tag      [ALU_ENT_NUM];
    logic [ALU_ENT_NUM-1:0] ent_dst;
    alu_op_e                ent_alu_op   [ALU_ENT_NUM];

    rs_dispatch_route i_route (
        .clk_i, .reset_i,
        .busy_i            (busy_vector_o),
        .we_1_i, .write_addr_1_i, .write_pc_1_i, .write_op_1_1_i, .write_op_1_2_i,
        .write_valid_1_1_i, .write_valid_1_2_i, .write_imm_1_i, .write_tag_1_i,
        .write_dst_1_i, .write_alu_op_1_i,
        .we_2_i, .write_addr_2_i, .write_pc_2_i, .write_op_2_1_i, .write_op_2_2_i,
        .write_valid_2_1_i, .write_valid_2_2_i, .write_imm_2_i, .write_tag_2_i,
        .write_dst_2_i, .write_alu_op_2_i,
        .ent_we_o          (route_we),
        .ent_pc_o          (route_pc),
        .ent_op_1_o        (route_op_1),
        .ent_op_2_o        (route_op_2),
        .ent_op_1_valid_o  (route_op_1_valid),
        .ent_op_2_valid_o  (route_op_2_valid),
        .ent_imm_o         (route_imm),
        .ent_tag_o         (route_tag),
        .ent_dst_o         (route_dst),
        .ent_alu_op_o      (route_alu_op)
    );

    for (genvar g = 0; g < ALU_ENT_NUM; g++) begin : g_entry
        rs_alu_entry i_entry (
            .clk_i, .reset_i,
            .we_i               (route_we[g]),
            .clear_i            (ent_clear[g]),
            .write_pc_i         (route_pc[g]),
            .write_op_1_i       (route_op_1[g]),
            .write_op_2_i       (route_op_2[g]),
            .write_op_1_valid_i (route_op_1_valid[g]),
            .write_op_2_valid_i (route_op_2_valid[g]),
            .write_imm_i        (route_imm[g]),
            .write_tag_i        (route_tag[g]),
            .write_dst_i        (route_dst[g]),
            .write_alu_op_i     (route_alu_op[g]),
            .fwd_valid_i, .fwd_result_i, .fwd_dst_i,
            .busy_o             (busy_vector_o[g]),
            .ready_o            (ready_o[g]),
            .exe_pc_o           (ent_pc[g]),
            .exe_op_1_o         (ent_op_1[g]),
            .exe_op_2_o         (ent_op_2[g]),
            .exe_imm_o          (ent_imm[g]),
            .exe_tag_o          (ent_tag[g]),
            .exe_dst_o          (ent_dst[g]),
            .exe_alu_op_o       (ent_alu_op[g])
        );
    end

    rs_issue_select i_select (
        .clk_i, .reset_i, .issue_addr_i, .clear_busy_i,
        .ent_ready_i   (ready_o),
        .ent_pc_i      (ent_pc),
        .ent_op_1_i    (ent_op_1),
        .ent_op_2_i    (ent_op_2),
        .ent_imm_i     (ent_imm),
        .ent_tag_i     (ent_tag),
        .ent_dst_i     (ent_dst),
        .ent_alu_op_i  (ent_alu_op),
        .ent_clear_o   (ent_clear),
        .exe_pc_o, .exe_op_1_o, .exe_op_2_o, .exe_imm_o,
        .exe_rrf_tag_o, .exe_dst_val_o, .exe_alu_op_o
    );

endmodule

/* verilog/rs_alu_entry.sv */
`timescale 1ns/1ps

module rs_alu_entry import rs_alu_pkg::*; (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               we_i,
    input  logic               clear_i,
    input  addr_t              write_pc_i,
    input  data_t              write_op_1_i,
    input  data_t              write_op_2_i,
    input  logic               write_op_1_valid_i,
    input  logic               write_op_2_valid_i,
    input  data_t              write_imm_i,
    input  rrf_tag_t           write_tag_i,
    input  logic               write_dst_i,
    input  alu_op_e            write_alu_op_i,
    input  logic [FWD_NUM-1:0] fwd_valid_i,
    input  data_t              fwd_result_i [FWD_NUM],
    input  rrf_tag_t           fwd_dst_i    [FWD_NUM],
    output logic               busy_o,
    output logic               ready_o,
    output addr_t              exe_pc_o,
    output data_t              exe_op_1_o,
    output data_t              exe_op_2_o,
    output data_t              exe_imm_o,
    output rrf_tag_t           exe_tag_o,
    output logic               exe_dst_o,
    output alu_op_e            exe_alu_op_o
);

    logic     busy_q;
    logic     op_1_valid_q;
    logic     op_2_valid_q;
    data_t    op_1_q;
    data_t    op_2_q;
    addr_t    pc_q;
    data_t    imm_q;
    rrf_tag_t tag_q;
    logic     dst_q;
    alu_op_e  alu_op_q;

    rrf_tag_t wait_tag_1;
    rrf_tag_t wait_tag_2;
    logic     hit_1;
    logic     hit_2;
    data_t    fwd_val_1;
    data_t    fwd_val_2;
    logic     wake_1;
    logic     wake_2;

    // a waiting operand carries its tag in the low bits
    assign wait_tag_1 = we_i ? write_op_1_i[RRF_SEL-1:0] : op_1_q[RRF_SEL-1:0];
    assign wait_tag_2 = we_i ? write_op_2_i[RRF_SEL-1:0] : op_2_q[RRF_SEL-1:0];

    always_comb begin
        hit_1     = 1'b0;
        hit_2     = 1'b0;
        fwd_val_1 = '0;
        fwd_val_2 = '0;
        for (int b = 0; b < FWD_NUM; b++) begin
            if (fwd_valid_i[b] && fwd_dst_i[b] == wait_tag_1) begin
                hit_1     = 1'b1;
                fwd_val_1 = fwd_result_i[b];
            end
            if (fwd_valid_i[b] && fwd_dst_i[b] == wait_tag_2) begin
                hit_2     = 1'b1;
                fwd_val_2 = fwd_result_i[b];
            end
        end
    end

    // bypass in the write cycle, snoop afterwards
    assign wake_1 = we_i ? (!write_op_1_valid_i && hit_1)
                         : (busy_q && !op_1_valid_q && hit_1);
    assign wake_2 = we_i ? (!write_op_2_valid_i && hit_2)
                         : (busy_q && !op_2_valid_q && hit_2);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q       <= 1'b0;
            op_1_valid_q <= 1'b0;
            op_2_valid_q <= 1'b0;
        end else if (we_i) begin
            busy_q       <= 1'b1;
            op_1_valid_q <= write_op_1_valid_i || wake_1;
            op_2_valid_q <= write_op_2_valid_i || wake_2;
        end else begin
            if (clear_i) begin
                busy_q <= 1'b0;
            end
            if (wake_1) begin
                op_1_valid_q <= 1'b1;
            end
            if (wake_2) begin
                op_2_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            pc_q     <= write_pc_i;
            imm_q    <= write_imm_i;
            tag_q    <= write_tag_i;
            dst_q    <= write_dst_i;
            alu_op_q <= write_alu_op_i;
        end
        if (wake_1) begin
            op_1_q <= fwd_val_1;
        end else if (we_i) begin
            op_1_q <= write_op_1_i;
        end
        if (wake_2) begin
            op_2_q <= fwd_val_2;
        end else if (we_i) begin
            op_2_q <= write_op_2_i;
        end
    end

    assign busy_o       = busy_q;
    assign ready_o      = busy_q && op_1_valid_q && op_2_valid_q;
    assign exe_pc_o     = pc_q;
    assign exe_op_1_o   = op_1_q;
    assign exe_op_2_o   = op_2_q;
    assign exe_imm_o    = imm_q;
    assign exe_tag_o    = tag_q;
    assign exe_dst_o    = dst_q;
    assign exe_alu_op_o = alu_op_q;

    // once woken, the entry stays ready and busy until issued
    a_ready_held: assert property (@(posedge clk_i) disable iff (reset_i)
        ready_o && !clear_i |=> ready_o && busy_o);

    // router and selector never touch the same entry in one cycle
    a_no_write_on_clear: assert property (@(posedge clk_i) disable iff (reset_i)
        !(we_i && clear_i));

endmodule

/* verilog/rs_alu_pkg.sv */
package rs_alu_pkg;

    localparam int ALU_ENT_NUM  = 8;
    localparam int ALU_ENT_SEL  = 3;
    localparam int DATA_LEN     = 32;
    localparam int ADDR_LEN     = 32;
    localparam int RRF_SEL      = 6;
    localparam int FWD_NUM      = 2;
    localparam int ALU_OP_WIDTH = 4;

    typedef logic [DATA_LEN-1:0]    data_t;
    typedef logic [ADDR_LEN-1:0]    addr_t;
    typedef logic [RRF_SEL-1:0]     rrf_tag_t;
    typedef logic [ALU_ENT_SEL-1:0] ent_sel_t;

    // alu opcodes, codes 4'ha..4'hf unused
    typedef enum logic [ALU_OP_WIDTH-1:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        SLL  = 4'h5,
        SRL  = 4'h6,
        SRA  = 4'h7,
        SLT  = 4'h8,
        SLTU = 4'h9
    } alu_op_e;

endpackage

/* verilog/rs_dispatch_route.sv */
`timescale 1ns/1ps

module rs_dispatch_route import rs_alu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic [ALU_ENT_NUM-1:0] busy_i,

    input  logic                   we_1_i,
    input  ent_sel_t               write_addr_1_i,
    input  addr_t                  write_pc_1_i,
    input  data_t                  write_op_1_1_i,
    input  data_t                  write_op_1_2_i,
    input  logic                   write_valid_1_1_i,
    input  logic                   write_valid_1_2_i,
    input  data_t                  write_imm_1_i,
    input  rrf_tag_t               write_tag_1_i,
    input  logic                   write_dst_1_i,
    input  alu_op_e                write_alu_op_1_i,

    input  logic                   we_2_i,
    input  ent_sel_t               write_addr_2_i,
    input  addr_t                  write_pc_2_i,
    input  data_t                  write_op_2_1_i,
    input  data_t                  write_op_2_2_i,
    input  logic                   write_valid_2_1_i,
    input  logic                   write_valid_2_2_i,
    input  data_t                  write_imm_2_i,
    input  rrf_tag_t               write_tag_2_i,
    input  logic                   write_dst_2_i,
    input  alu_op_e                write_alu_op_2_i,

    output logic [ALU_ENT_NUM-1:0] ent_we_o,
    output addr_t                  ent_pc_o     [ALU_ENT_NUM],
    output data_t                  ent_op_1_o   [ALU_ENT_NUM],
    output data_t                  ent_op_2_o   [ALU_ENT_NUM],
    output logic [ALU_ENT_NUM-1:0] ent_op_1_valid_o,
    output logic [ALU_ENT_NUM-1:0] ent_op_2_valid_o,
    output data_t                  ent_imm_o    [ALU_ENT_NUM],
    output rrf_tag_t               ent_tag_o    [ALU_ENT_NUM],
    output logic [ALU_ENT_NUM-1:0] ent_dst_o,
    output alu_op_e                ent_alu_op_o [ALU_ENT_NUM]
);

    logic [ALU_ENT_NUM-1:0] hit_1;
    logic [ALU_ENT_NUM-1:0] hit_2;

    // one-hot target of each slot
    always_comb begin
        hit_1 = '0;
        hit_2 = '0;
        hit_1[write_addr_1_i] = we_1_i;
        hit_2[write_addr_2_i] = we_2_i;
    end

    assign ent_we_o = hit_1 | hit_2;

    // slot 2 only where it targets the entry, slot 1 elsewhere
    always_comb begin
        for (int e = 0; e < ALU_ENT_NUM; e++) begin
            if (hit_2[e]) begin
                ent_pc_o[e]         = write_pc_2_i;
                ent_op_1_o[e]       = write_op_2_1_i;
                ent_op_2_o[e]       = write_op_2_2_i;
                ent_op_1_valid_o[e] = write_valid_2_1_i;
                ent_op_2_valid_o[e] = write_valid_2_2_i;
                ent_imm_o[e]        = write_imm_2_i;
                ent_tag_o[e]        = write_tag_2_i;
                ent_dst_o[e]        = write_dst_2_i;
                ent_alu_op_o[e]     = write_alu_op_2_i;
            end else begin
                ent_pc_o[e]         = write_pc_1_i;
                ent_op_1_o[e]       = write_op_1_1_i;
                ent_op_2_o[e]       = write_op_1_2_i;
                ent_op_1_valid_o[e] = write_valid_1_1_i;
                ent_op_2_valid_o[e] = write_valid_1_2_i;
                ent_imm_o[e]        = write_imm_1_i;
                ent_tag_o[e]        = write_tag_1_i;
                ent_dst_o[e]        = write_dst_1_i;
                ent_alu_op_o[e]     = write_alu_op_1_i;
            end
        end
    end

    a_slot_addr_distinct: assert property (@(posedge clk_i) disable iff (reset_i)
        we_1_i && we_2_i |-> write_addr_1_i != write_addr_2_i);

    // allocator hands out free entries only
    a_slot_1_free: assert property (@(posedge clk_i) disable iff (reset_i)
        we_1_i |-> !busy_i[write_addr_1_i]);
    a_slot_2_free: assert property (@(posedge clk_i) disable iff (reset_i)
        we_2_i |-> !busy_i[write_addr_2_i]);

endmodule

/* verilog/rs_issue_select.sv */
`timescale 1ns/1ps

module rs_issue_select import rs_alu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  ent_sel_t               issue_addr_i,
    input  logic                   clear_busy_i,
    input  logic [ALU_ENT_NUM-1:0] ent_ready_i,
    input  addr_t                  ent_pc_i     [ALU_ENT_NUM],
    input  data_t                  ent_op_1_i   [ALU_ENT_NUM],
    input  data_t                  ent_op_2_i   [ALU_ENT_NUM],
    input  data_t                  ent_imm_i    [ALU_ENT_NUM],
    input  rrf_tag_t               ent_tag_i    [ALU_ENT_NUM],
    input  logic [ALU_ENT_NUM-1:0] ent_dst_i,
    input  alu_op_e                ent_alu_op_i [ALU_ENT_NUM],

    output logic [ALU_ENT_NUM-1:0] ent_clear_o,
    output addr_t                  exe_pc_o,
    output data_t                  exe_op_1_o,
    output data_t                  exe_op_2_o,
    output data_t                  exe_imm_o,
    output rrf_tag_t               exe_rrf_tag_o,
    output logic                   exe_dst_val_o,
    output alu_op_e                exe_alu_op_o
);

    // free the issued entry
    always_comb begin
        ent_clear_o = '0;
        ent_clear_o[issue_addr_i] = clear_busy_i;
    end

    // zero latency read of the addressed entry
    assign exe_pc_o      = ent_pc_i[issue_addr_i];
    assign exe_op_1_o    = ent_op_1_i[issue_addr_i];
    assign exe_op_2_o    = ent_op_2_i[issue_addr_i];
    assign exe_imm_o     = ent_imm_i[issue_addr_i];
    assign exe_rrf_tag_o = ent_tag_i[issue_addr_i];
    assign exe_dst_val_o = ent_dst_i[issue_addr_i];
    assign exe_alu_op_o  = ent_alu_op_i[issue_addr_i];

    // issue logic only drains entries whose operands have arrived
    a_clear_on_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        clear_busy_i |-> ent_ready_i[issue_addr_i]);

endmodule
